// ==== fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// width of data words and of the program counter
`define FETCH_XLEN 32

// first instruction address after reset
`define FETCH_RESET_PC 32'h0000_0000

// word handed to decode for an encoding the expander rejects
// all zeros is itself an illegal instruction, so decode traps on it
`define FETCH_ILLEGAL_WORD 32'h0000_0000

`endif

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] rv_word_t;
    typedef logic [15:0] rv_half_t;

    // base instruction fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_instr_fields_t;

    // the same word seen as two halfwords, lo sits at the lower address
    typedef struct packed {
        rv_half_t hi;
        rv_half_t lo;
    } rv_halves_t;

    typedef union packed {
        rv_instr_fields_t instr;
        rv_halves_t       half;
    } rv_fetch_word_u;

    // opcodes that compressed forms expand to
    typedef enum logic [6:0] {
        load   = 7'b0000011,
        op_imm = 7'b0010011,
        store  = 7'b0100011,
        op     = 7'b0110011,
        lui    = 7'b0110111,
        branch = 7'b1100011,
        jalr   = 7'b1100111,
        jal    = 7'b1101111,
        system = 7'b1110011
    } rv_opcode_e;

    // low two bits of a halfword
    typedef enum logic [1:0] {
        c0             = 2'b00,
        c1             = 2'b01,
        c2             = 2'b10,
        not_compressed = 2'b11
    } rvc_quadrant_e;

endpackage

// ==== fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

    // byte address of an instruction, bit 0 stays clear
    typedef logic [`FETCH_XLEN-1:0] pc_t;

    // upper halfword kept back from the last fetched word
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-3:0] adr;    // word address it came from
        rv_isa_pkg::rv_half_t   data;
    } half_buf_t;

endpackage

// ==== fetch_wb_master.sv ====
module fetch_wb_master
    import rv_isa_pkg::*, fetch_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           fetch_req_i,
    input  logic [29:0]    fetch_adr_i,
    input  logic           wb_ack_i,
    input  rv_word_t       wb_dat_i,
    output logic           wb_cyc_o,
    output logic           wb_stb_o,
    output logic           wb_we_o,
    output pc_t            wb_adr_o,
    output logic           word_valid_o,
    output rv_fetch_word_u word_o
);

    logic        busy_q;    // a classic read is on the bus
    logic [29:0] adr_q;

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;       // single beat so stb follows cyc
    assign wb_we_o  = 1'b0;         // read only
    assign wb_adr_o = {adr_q, 2'b00};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= busy_q && wb_ack_i;
            if (!busy_q) begin
                // request is still held in the cycle its word comes back
                busy_q <= fetch_req_i && !word_valid_o;
            end else if (wb_ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busy_q) begin
            adr_q <= fetch_adr_i;   // frozen for the whole cycle
        end
        if (busy_q && wb_ack_i) begin
            word_o <= wb_dat_i;
        end
    end

    // the request still held during the handover must not start a second read
    a_no_restart: assert property (@(posedge clk_i) disable iff (reset_i)
        word_valid_o |=> !wb_cyc_o);

    a_adr_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o));

endmodule

// ==== rvc_expander.sv ====
`include "fetch_cfg.svh"

module rvc_expander
    import rv_isa_pkg::*;
(
    input  rv_half_t half_i,
    output rv_word_t instr_o,
    output logic     illegal_o
);

    logic [2:0]  funct3;
    logic [4:0]  rd;        // full register fields
    logic [4:0]  rs2;
    logic [4:0]  rd_p;      // x8..x15 short fields
    logic [4:0]  rs1_p;
    logic [11:0] imm6;      // sign extended 6-bit immediate
    rv_word_t    word;

    function automatic rv_word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd_f, rv_opcode_e opc);
        return {imm, rs1, f3, rd_f, opc};
    endfunction

    function automatic rv_word_t enc_r(logic [6:0] f7, logic [4:0] rs2_f, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd_f);
        return {f7, rs2_f, rs1, f3, rd_f, op};
    endfunction

    function automatic rv_word_t enc_s(logic [11:0] imm, logic [4:0] rs2_f, logic [4:0] rs1);
        return {imm[11:5], rs2_f, rs1, 3'b010, imm[4:0], store};
    endfunction

    assign funct3 = half_i[15:13];
    assign rd     = half_i[11:7];
    assign rs2    = half_i[6:2];
    assign rd_p   = {2'b01, half_i[4:2]};
    assign rs1_p  = {2'b01, half_i[9:7]};
    assign imm6   = {{6{half_i[12]}}, half_i[12], half_i[6:2]};

    always_comb begin
        word      = '0;
        illegal_o = 1'b0;
        case (rvc_quadrant_e'(half_i[1:0]))
            c0: begin
                case (funct3)
                    3'b000: begin   // c.addi4spn, a zero immediate is reserved
                        word = enc_i({2'b00, half_i[10:7], half_i[12:11], half_i[5], half_i[6],
                                      2'b00}, 5'd2, 3'b000, rd_p, op_imm);
                        illegal_o = half_i[12:5] == 8'd0;
                    end
                    3'b010: word = enc_i({5'd0, half_i[5], half_i[12:10], half_i[6], 2'b00},
                                         rs1_p, 3'b010, rd_p, load);            // c.lw
                    3'b110: word = enc_s({5'd0, half_i[5], half_i[12:10], half_i[6], 2'b00},
                                         rd_p, rs1_p);                          // c.sw
                    default: illegal_o = 1'b1;
                endcase
            end
            c1: begin
                case (funct3)
                    3'b000: word = enc_i(imm6, rd, 3'b000, rd, op_imm);     // c.addi, c.nop
                    3'b001, 3'b101: begin   // c.jal links x1, c.j links x0
                        word = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7],
                                half_i[2], half_i[11], half_i[5:3], {9{half_i[12]}},
                                4'b0000, !funct3[2], jal};
                    end
                    3'b010: word = enc_i(imm6, 5'd0, 3'b000, rd, op_imm);   // c.li
                    3'b011: begin
                        if (rd == 5'd2) begin   // c.addi16sp
                            word = enc_i({{3{half_i[12]}}, half_i[4:3], half_i[5], half_i[2],
                                          half_i[6], 4'b0000}, 5'd2, 3'b000, 5'd2, op_imm);
                        end else begin          // c.lui
                            word = {{15{half_i[12]}}, half_i[6:2], rd, lui};
                        end
                        illegal_o = {half_i[12], half_i[6:2]} == 6'd0;
                    end
                    3'b100: begin
                        case (half_i[11:10])
                            2'b10: word = enc_i(imm6, rs1_p, 3'b111, rs1_p, op_imm);  // c.andi
                            2'b11: begin
                                illegal_o = half_i[12];     // rv64 word forms
                                case (half_i[6:5])
                                    2'b00: word = enc_r(7'b0100000, rd_p, rs1_p, 3'b000, rs1_p);
                                    2'b01: word = enc_r(7'd0, rd_p, rs1_p, 3'b100, rs1_p);
                                    2'b10: word = enc_r(7'd0, rd_p, rs1_p, 3'b110, rs1_p);
                                    default: word = enc_r(7'd0, rd_p, rs1_p, 3'b111, rs1_p);
                                endcase
                            end
                            default: illegal_o = 1'b1;  // c.srli and c.srai left out
                        endcase
                    end
                    default: begin  // c.beqz, c.bnez
                        word = {{4{half_i[12]}}, half_i[6:5], half_i[2], 5'd0, rs1_p, 2'b00,
                                funct3[0], half_i[11:10], half_i[4:3], half_i[12], branch};
                    end
                endcase
            end
            c2: begin
                case (funct3)
                    3'b000: begin   // c.slli, shamt[5] set is rv64 only
                        word      = enc_i({7'd0, rs2}, rd, 3'b001, rd, op_imm);
                        illegal_o = half_i[12];
                    end
                    3'b010: begin   // c.lwsp
                        word = enc_i({4'd0, half_i[3:2], half_i[12], half_i[6:4], 2'b00},
                                     5'd2, 3'b010, rd, load);
                        illegal_o = rd == 5'd0;
                    end
                    3'b100: begin
                        if (!half_i[12]) begin
                            if (rs2 == 5'd0) begin  // c.jr
                                word      = enc_i(12'd0, rd, 3'b000, 5'd0, jalr);
                                illegal_o = rd == 5'd0;
                            end else begin
                                word = enc_r(7'd0, rs2, 5'd0, 3'b000, rd);  // c.mv
                            end
                        end else if (rs2 != 5'd0) begin
                            word = enc_r(7'd0, rs2, rd, 3'b000, rd);        // c.add
                        end else if (rd == 5'd0) begin
                            word = enc_i(12'd1, 5'd0, 3'b000, 5'd0, system); // c.ebreak
                        end else begin
                            word = enc_i(12'd0, rd, 3'b000, 5'd1, jalr);    // c.jalr
                        end
                    end
                    3'b110: word = enc_s({4'd0, half_i[8:7], half_i[12:9], 2'b00}, rs2, 5'd2);
                    default: illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase
    end

    assign instr_o = illegal_o ? `FETCH_ILLEGAL_WORD : word;

endmodule

// ==== fetch_align_unit.sv ====
`include "fetch_cfg.svh"

module fetch_align_unit
    import rv_isa_pkg::*, fetch_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           redirect_i,
    input  pc_t            redirect_pc_i,
    input  logic           word_valid_i,
    input  rv_fetch_word_u word_i,
    input  rv_word_t       exp_instr_i,
    input  logic           exp_illegal_i,
    output logic           fetch_req_o,
    output logic [29:0]    fetch_adr_o,
    output rv_half_t       exp_half_o,
    output logic           valid_o,
    output logic           compressed_o,
    output logic           illegal_o,
    output rv_word_t       instr_o,
    output pc_t            pc_o
);

    pc_t            pc_q;
    half_buf_t      buf_q;
    logic           discard_q;      // word in flight belongs to the old path
    logic [29:0]    pc_word;
    logic           word_hit;
    logic           cur_hit;
    logic           nxt_hit;
    logic           buf_hit;
    logic           first_ok;
    logic           second_ok;
    rv_half_t       first_half;
    rv_half_t       second_half;
    logic           is_comp;
    logic           step_done;
    logic           slot_free;
    logic           req_start;
    logic [29:0]    need_adr;
    rv_fetch_word_u out_view;

    assign pc_word   = pc_q[`FETCH_XLEN-1:2];
    assign word_hit  = word_valid_i && !discard_q;
    assign cur_hit   = word_hit && (fetch_adr_o == pc_word);
    assign nxt_hit   = word_hit && (fetch_adr_o == pc_word + 30'd1);
    assign buf_hit   = buf_q.valid && (buf_q.adr == pc_word);
    assign slot_free = !valid_o || !stall_i;   // output empty or taken this cycle

    // where the two halves of the instruction at pc come from
    always_comb begin
        if (!pc_q[1]) begin
            first_ok    = cur_hit;
            first_half  = word_i.half.lo;
            second_ok   = cur_hit;
            second_half = word_i.half.hi;
        end else if (buf_hit) begin
            first_ok    = 1'b1;
            first_half  = buf_q.data;
            second_ok   = nxt_hit;          // spans into the next word
            second_half = word_i.half.lo;
        end else begin
            // upper half of a fresh word, the rest waits for the buffer
            first_ok    = cur_hit;
            first_half  = word_i.half.hi;
            second_ok   = 1'b0;
            second_half = word_i.half.lo;
        end
    end

    assign is_comp    = first_half[1:0] != not_compressed;
    assign step_done  = first_ok && (is_comp || second_ok);
    assign need_adr   = (first_ok && pc_q[1]) ? pc_word + 30'd1 : pc_word;
    assign req_start  = !redirect_i && !word_valid_i && slot_free && !step_done && !fetch_req_o;
    assign exp_half_o = first_half;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q        <= `FETCH_RESET_PC;
            valid_o     <= 1'b0;
            fetch_req_o <= 1'b0;
            discard_q   <= 1'b0;
        end else if (redirect_i) begin
            pc_q        <= redirect_pc_i;
            valid_o     <= 1'b0;
            fetch_req_o <= fetch_req_o && !word_valid_i;  // accepted read still finishes
            discard_q   <= fetch_req_o && !word_valid_i;
        end else begin
            if (word_valid_i) begin
                fetch_req_o <= 1'b0;
                discard_q   <= 1'b0;
            end else if (req_start) begin
                fetch_req_o <= 1'b1;
            end
            if (slot_free) begin
                valid_o <= step_done;
                if (step_done) begin
                    pc_q <= pc_q + (is_comp ? pc_t'(2) : pc_t'(4));
                end
            end
        end
    end

    // every fresh word leaves its upper half behind
    always_ff @(posedge clk_i) begin
        if (reset_i || redirect_i) begin
            buf_q.valid <= 1'b0;
        end else if (word_hit) begin
            buf_q <= '{valid: 1'b1, adr: fetch_adr_o, data: word_i.half.hi};
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_start) begin
            fetch_adr_o <= need_adr;
        end
        if (!redirect_i && slot_free && step_done) begin
            instr_o      <= is_comp ? exp_instr_i : {second_half, first_half};
            pc_o         <= pc_q;
            compressed_o <= is_comp;
            illegal_o    <= is_comp && exp_illegal_i;
        end
    end

    assign out_view = instr_o;

    a_pc_even: assert property (@(posedge clk_i) disable iff (reset_i) !pc_q[0]);

    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_o && stall_i && !redirect_i) |=>
            (valid_o && $stable(instr_o) && $stable(pc_o) &&
             $stable(compressed_o) && $stable(illegal_o)));

    // expanded words must carry one of the base opcodes
    a_rvc_opcode: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_o && compressed_o && !illegal_o) |->
            (rv_opcode_e'(out_view.instr.opcode) inside
                {op_imm, op, lui, load, store, branch, jal, jalr, system}));

endmodule

// ==== fetch_top.sv ====
module fetch_top
    import rv_isa_pkg::*, fetch_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     wb_ack_i,
    input  rv_word_t wb_dat_i,
    input  logic     stall_i,
    input  logic     redirect_i,
    input  pc_t      redirect_pc_i,
    output logic     wb_cyc_o,
    output logic     wb_stb_o,
    output logic     wb_we_o,
    output pc_t      wb_adr_o,
    output logic     valid_o,
    output rv_word_t instr_o,
    output pc_t      pc_o,
    output logic     compressed_o,
    output logic     illegal_o
);

    logic           fetch_req;
    logic [29:0]    fetch_adr;
    logic           word_valid;
    rv_fetch_word_u word;
    rv_half_t       exp_half;
    rv_word_t       exp_instr;
    logic           exp_illegal;

    fetch_wb_master wb_master_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fetch_req_i  (fetch_req),
        .fetch_adr_i  (fetch_adr),
        .wb_ack_i     (wb_ack_i),
        .wb_dat_i     (wb_dat_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .word_valid_o (word_valid),
        .word_o       (word)
    );

    fetch_align_unit align_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .exp_instr_i   (exp_instr),
        .exp_illegal_i (exp_illegal),
        .fetch_req_o   (fetch_req),
        .fetch_adr_o   (fetch_adr),
        .exp_half_o    (exp_half),
        .valid_o       (valid_o),
        .compressed_o  (compressed_o),
        .illegal_o     (illegal_o),
        .instr_o       (instr_o),
        .pc_o          (pc_o)
    );

    rvc_expander expander_inst (
        .half_i    (exp_half),
        .instr_o   (exp_instr),
        .illegal_o (exp_illegal)
    );

endmodule

// ==== tb_fetch_top.sv ====
`include "fetch_cfg.svh"

module tb_fetch_top
    import rv_isa_pkg::*, fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;   // about four times the tests' total length

    logic     clk_i         = 1'b0;
    logic     reset_i       = 1'b1;
    logic     wb_ack_i      = 1'b0;
    rv_word_t wb_dat_i      = '0;
    logic     stall_i       = 1'b0;
    logic     redirect_i    = 1'b0;
    pc_t      redirect_pc_i = '0;
    logic     wb_cyc_o;
    logic     wb_stb_o;
    logic     wb_we_o;
    pc_t      wb_adr_o;
    logic     valid_o;
    rv_word_t instr_o;
    pc_t      pc_o;
    logic     compressed_o;
    logic     illegal_o;

    rv_half_t    mem [0:1023];      // 2 KB of program memory
    logic [31:0] rng_state = 32'd12394;
    int          wait_cnt  = 0;
    int          cycles    = 0;
    int          errors    = 0;
    int          checks    = 0;
    int          tests     = 0;
    int          test_errs = 0;
    string       cur_test;
    pc_t         prog_pc;
    bit          record;

    // expected outputs in program order
    pc_t      exp_pc_q [$];
    rv_word_t exp_instr_q [$];
    logic     exp_comp_q [$];
    logic     exp_ill_q [$];

    fetch_top fetch_top_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .wb_ack_i      (wb_ack_i),
        .wb_dat_i      (wb_dat_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .valid_o       (valid_o),
        .instr_o       (instr_o),
        .pc_o          (pc_o),
        .compressed_o  (compressed_o),
        .illegal_o     (illegal_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // wishbone slave with 0 to 3 wait states per read
    always @(posedge clk_i) begin
        if (reset_i) begin
            wb_ack_i <= 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
            wait_cnt <= xorshift() % 4;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_cnt == 0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= {mem[{wb_adr_o[10:2], 1'b1}], mem[{wb_adr_o[10:2], 1'b0}]};
                check_flag("wb_we", 1'b0, wb_we_o);     // fetch only reads
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: test %s still waiting after %0d cycles", cur_test, cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_instr(rv_word_t exp, rv_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s instr: expected %h, actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_pc(pc_t exp, pc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s pc: expected %h, actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(string name, pc_t base);
        cur_test  = name;
        test_errs = errors;
        prog_pc   = base;
        record    = 1'b1;
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s: %s (%0d errors)", cur_test,
                 (errors == test_errs) ? "ok" : "failed", errors - test_errs);
    endtask

    task automatic put_half(rv_half_t h);
        mem[prog_pc[10:1]] = h;
        prog_pc += 32'd2;
    endtask

    task automatic expect_out(rv_word_t w, logic comp, logic ill);
        if (record) begin
            exp_pc_q.push_back(prog_pc);
            exp_instr_q.push_back(w);
            exp_comp_q.push_back(comp);
            exp_ill_q.push_back(ill);
        end
    endtask

    task automatic emit_comp(rv_half_t h, rv_word_t expanded);
        expect_out(expanded, 1'b1, 1'b0);
        put_half(h);
    endtask

    task automatic emit_bad(rv_half_t h);
        expect_out(`FETCH_ILLEGAL_WORD, 1'b1, 1'b1);
        put_half(h);
    endtask

    task automatic emit_full(rv_word_t w);
        expect_out(w, 1'b0, 1'b0);
        put_half(w[15:0]);
        put_half(w[31:16]);
    endtask

    task automatic emit_random_full();
        logic [31:0] r;
        r = xorshift();
        emit_full({r[31:2], 2'b11});
    endtask

    task automatic jump_to(pc_t target);
        @(posedge clk_i);
        redirect_i    <= 1'b1;
        redirect_pc_i <= target;
        @(posedge clk_i);
        redirect_i    <= 1'b0;
    endtask

    // take outputs until every expected entry has been seen
    task automatic collect(bit random_stall);
        rv_word_t held_instr;
        pc_t      held_pc;
        logic     held_comp;
        logic     held_ill;
        bit       was_stalled;
        was_stalled = 1'b0;
        while (exp_pc_q.size() > 0) begin
            @(posedge clk_i);
            if (random_stall) begin
                stall_i <= (xorshift() & 32'd1) != 32'd0;
            end
            @(negedge clk_i);
            if (was_stalled && (!valid_o || instr_o !== held_instr || pc_o !== held_pc ||
                                compressed_o !== held_comp || illegal_o !== held_ill)) begin
                errors++;
                $display("** Error %s: output changed while stalled at pc %h", cur_test, held_pc);
            end
            was_stalled = 1'b0;
            if (valid_o && stall_i) begin
                held_instr  = instr_o;
                held_pc     = pc_o;
                held_comp   = compressed_o;
                held_ill    = illegal_o;
                was_stalled = 1'b1;
            end else if (valid_o) begin
                check_pc(exp_pc_q.pop_front(), pc_o);
                check_instr(exp_instr_q.pop_front(), instr_o);
                check_flag("compressed", exp_comp_q.pop_front(), compressed_o);
                check_flag("illegal", exp_ill_q.pop_front(), illegal_o);
            end
        end
        @(posedge clk_i);
        stall_i <= 1'b0;
    endtask

    task automatic test_aligned();
        start_test("aligned", 32'h0000_0000);
        repeat (8) emit_random_full();
        jump_to(32'h0000_0000);
        collect(1'b0);
        finish_test();
    endtask

    task automatic test_mixed();
        start_test("mixed", 32'h0000_0040);
        emit_comp(16'h0001, 32'h0000_0013);
        emit_random_full();                         // spans 0x42..0x45
        emit_comp(16'h557d, 32'hfff0_0513);
        emit_random_full();
        emit_comp(16'h0505, 32'h0015_0513);
        emit_random_full();
        emit_random_full();
        emit_comp(16'h852e, 32'h00b0_0533);
        emit_comp(16'h952e, 32'h00b5_0533);
        emit_random_full();
        jump_to(32'h0000_0040);
        collect(1'b0);
        finish_test();
    endtask

    task automatic test_expansion();
        start_test("expansion", 32'h0000_0080);
        emit_comp(16'h0001, 32'h0000_0013);         // c.nop
        emit_comp(16'h0505, 32'h0015_0513);         // c.addi
        emit_comp(16'h557d, 32'hfff0_0513);         // c.li
        emit_comp(16'h6585, 32'h0000_15b7);         // c.lui
        emit_comp(16'h6141, 32'h0101_0113);         // c.addi16sp
        emit_comp(16'h0040, 32'h0041_0413);         // c.addi4spn
        emit_comp(16'h852e, 32'h00b0_0533);         // c.mv
        emit_comp(16'h952e, 32'h00b5_0533);
        emit_comp(16'h8c05, 32'h4094_0433);         // c.sub
        emit_comp(16'h8c25, 32'h0094_4433);
        emit_comp(16'h8c45, 32'h0094_6433);
        emit_comp(16'h8c65, 32'h0094_7433);
        emit_comp(16'h880d, 32'h0034_7413);         // c.andi
        emit_comp(16'h050a, 32'h0025_1513);         // c.slli
        emit_comp(16'h4044, 32'h0044_2483);         // c.lw
        emit_comp(16'hc404, 32'h0094_2423);         // c.sw
        emit_comp(16'h4522, 32'h0081_2503);         // c.lwsp
        emit_comp(16'hc62a, 32'h00a1_2623);         // c.swsp
        emit_comp(16'ha021, 32'h0080_006f);         // c.j
        emit_comp(16'h3ff5, 32'hffdf_f0ef);         // c.jal
        emit_comp(16'hc011, 32'h0004_0263);         // c.beqz
        emit_comp(16'he099, 32'h0004_9363);         // c.bnez
        emit_comp(16'h8082, 32'h0000_8067);         // c.jr
        emit_comp(16'h9502, 32'h0005_00e7);         // c.jalr
        emit_comp(16'h9002, 32'h0010_0073);         // c.ebreak
        jump_to(32'h0000_0080);
        collect(1'b0);
        finish_test();
    endtask

    task automatic test_illegal();
        start_test("illegal", 32'h0000_00c0);
        emit_comp(16'h0001, 32'h0000_0013);
        emit_bad(16'h0000);
        emit_comp(16'h557d, 32'hfff0_0513);
        emit_bad(16'h6101);                         // c.addi16sp with zero immediate
        emit_comp(16'h0505, 32'h0015_0513);
        emit_random_full();
        jump_to(32'h0000_00c0);
        collect(1'b0);
        finish_test();
    endtask

    task automatic test_redirect();
        start_test("redirect", 32'h0000_0100);
        repeat (3) emit_random_full();
        record = 1'b0;                              // rest of the old path is not collected
        repeat (5) emit_random_full();
        jump_to(32'h0000_0100);
        collect(1'b0);
        record  = 1'b1;
        prog_pc = 32'h0000_0182;
        emit_comp(16'h0505, 32'h0015_0513);
        emit_random_full();
        emit_comp(16'h852e, 32'h00b0_0533);
        emit_random_full();
        @(negedge clk_i);
        while (!(wb_cyc_o && !wb_ack_i)) @(negedge clk_i);
        jump_to(32'h0000_0182);
        collect(1'b0);
        finish_test();
    endtask

    task automatic test_stall();
        start_test("stall", 32'h0000_0200);
        repeat (3) begin
            emit_comp(16'h0505, 32'h0015_0513);
            emit_random_full();
            emit_random_full();
            emit_comp(16'h8c25, 32'h0094_4433);
        end
        jump_to(32'h0000_0200);
        collect(1'b1);
        finish_test();
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 16'h0000;
        end
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        test_aligned();
        test_mixed();
        test_expansion();
        test_illegal();
        test_redirect();
        test_stall();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== fetch_top.f ====
+incdir+.
rv_isa_pkg.sv
fetch_pkg.sv
fetch_wb_master.sv
rvc_expander.sv
fetch_align_unit.sv
fetch_top.sv
tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       := tb_fetch_top
FILELIST  := fetch_top.f
SRCS      := $(shell grep -v '^+' $(FILELIST)) fetch_cfg.svh
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
